// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f list.f --top-module ooo_tb

sim:
	verilator --binary --timing -Wno-fatal -f list.f --top-module ooo_tb -Mdir obj_dir
	./obj_dir/Vooo_tb | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/ooo_tb.sv
`timescale 1ns/10ps

module ooo_tb
    import ooo_pkg::*;
();

    logic  clock;
    logic  rst_n;
    logic  dispatch_valid;
    op_e   dispatch_op;
    arn_t  dispatch_dest;
    arn_t  dispatch_src1;
    arn_t  dispatch_src2;
    word_t dispatch_imm;
    logic  structural_hazard;
    logic  commit_valid;
    logic  commit_wr_en;
    arn_t  commit_dest;
    word_t commit_value;

    // instruction table
    op_e   tbl_op   [$];
    arn_t  tbl_dest [$];
    arn_t  tbl_src1 [$];
    arn_t  tbl_src2 [$];
    word_t tbl_imm  [$];

    // expected commits in program order
    arn_t  exp_dest  [$];
    word_t exp_value [$];
    logic  exp_wr_en [$];

    word_t       arch_regs [2**$bits(arn_t)];
    integer      seed;
    int          cycle_count = 0;
    int          timeout_limit;
    int          commits_seen = 0;
    int          idx;
    logic        saw_hazard;
    logic        held;
    logic [31:0] rnd;
    logic [31:0] rnd_imm;

    ooo ooo_inst (
        .clock(clock),
        .rst_n(rst_n),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_imm(dispatch_imm),
        .structural_hazard(structural_hazard),
        .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en),
        .commit_dest(commit_dest),
        .commit_value(commit_value)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic word_t model_result(op_e op, word_t a, word_t b, word_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return imm;
        endcase
    endfunction

    // appends to the table and runs the in-order model
    task automatic queue_instr(op_e op, arn_t dest, arn_t src1, arn_t src2, word_t imm);
        word_t result;
        result = model_result(op, arch_regs[src1], arch_regs[src2], imm);
        tbl_op.push_back(op);
        tbl_dest.push_back(dest);
        tbl_src1.push_back(src1);
        tbl_src2.push_back(src2);
        tbl_imm.push_back(imm);
        exp_dest.push_back(dest);
        exp_wr_en.push_back(dest != '0);
        exp_value.push_back(result);
        // register 0 stays zero
        if (dest != '0) begin
            arch_regs[dest] = result;
        end
    endtask

    task automatic end_in_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_dest(arn_t expected, arn_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_dest expected %h got %h at commit %0d",
                     expected, actual, commits_seen);
            end_in_failure();
        end
    endtask

    task automatic check_value(word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_value expected %h got %h at commit %0d",
                     expected, actual, commits_seen);
            end_in_failure();
        end
    endtask

    task automatic check_wr_en(logic expected, logic actual);
        if (actual !== expected) begin
            $display("[FAIL] commit_wr_en expected %h got %h at commit %0d",
                     expected, actual, commits_seen);
            end_in_failure();
        end
    endtask

    task automatic expect_low(string name, logic actual);
        if (actual !== 1'b0) begin
            $display("[FAIL] %s expected %h got %h", name, 1'b0, actual);
            end_in_failure();
        end
    endtask

    // each commit is checked against the model in order
    always @(negedge clock) begin
        if (rst_n === 1'b1 && commit_valid === 1'b1) begin
            if (exp_dest.size() == 0) begin
                $display("ERROR: a commit arrived with no instruction left to retire");
                end_in_failure();
            end else begin
                check_dest(exp_dest[0], commit_dest);
                check_wr_en(exp_wr_en[0], commit_wr_en);
                if (exp_wr_en[0]) begin
                    check_value(exp_value[0], commit_value);
                end
                void'(exp_dest.pop_front());
                void'(exp_wr_en.pop_front());
                void'(exp_value.pop_front());
                commits_seen = commits_seen + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("ERROR: timed out after %0d cycles with %0d commits outstanding",
                     cycle_count, exp_dest.size());
            end_in_failure();
        end
    end

    initial begin
        rst_n          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_imm   = '0;
        seed           = 19;
        saw_hazard     = 1'b0;
        held           = 1'b0;
        for (int r = 0; r < 2**$bits(arn_t); r++) begin
            arch_regs[r] = '0;
        end

        // load immediates
        queue_instr(OP_LI, 3'd1, 3'd0, 3'd0, 16'h0005);
        queue_instr(OP_LI, 3'd2, 3'd0, 3'd0, 16'h0003);
        queue_instr(OP_LI, 3'd3, 3'd0, 3'd0, 16'h1234);
        queue_instr(OP_LI, 3'd4, 3'd0, 3'd0, 16'h00f0);
        // dependent chain
        queue_instr(OP_ADD, 3'd5, 3'd1, 3'd2, 16'h0000);
        queue_instr(OP_SUB, 3'd6, 3'd5, 3'd2, 16'h0000);
        queue_instr(OP_AND, 3'd7, 3'd6, 3'd3, 16'h0000);
        queue_instr(OP_XOR, 3'd5, 3'd7, 3'd5, 16'h0000);
        queue_instr(OP_SUB, 3'd1, 3'd5, 3'd6, 16'h0000);
        // multiply overtaken by independent ALU ops
        queue_instr(OP_MUL, 3'd6, 3'd3, 3'd4, 16'h0000);
        queue_instr(OP_ADD, 3'd7, 3'd1, 3'd2, 16'h0000);
        queue_instr(OP_XOR, 3'd2, 3'd2, 3'd4, 16'h0000);
        queue_instr(OP_AND, 3'd3, 3'd1, 3'd1, 16'h0000);
        queue_instr(OP_LI, 3'd4, 3'd0, 3'd0, 16'h0101);
        queue_instr(OP_ADD, 3'd5, 3'd6, 3'd7, 16'h0000);
        // register 0 as destination and source
        queue_instr(OP_LI, 3'd0, 3'd0, 3'd0, 16'hbeef);
        queue_instr(OP_ADD, 3'd0, 3'd1, 3'd2, 16'h0000);
        queue_instr(OP_ADD, 3'd4, 3'd0, 3'd1, 16'h0000);
        queue_instr(OP_MUL, 3'd0, 3'd3, 3'd3, 16'h0000);
        queue_instr(OP_XOR, 3'd7, 3'd0, 3'd0, 16'h0000);
        // burst of dependent multiplies fills the queues
        repeat (8) begin
            queue_instr(OP_MUL, 3'd1, 3'd1, 3'd2, 16'h0000);
            queue_instr(OP_ADD, 3'd2, 3'd1, 3'd2, 16'h0000);
        end
        // random program
        repeat (200) begin
            rnd     = $random(seed);
            rnd_imm = $random(seed);
            queue_instr(op_e'(rnd[2:0] % 3'd6), rnd[5:3], rnd[8:6], rnd[11:9],
                        rnd_imm[15:0]);
        end
        timeout_limit = 40 * tbl_op.size() + 100;

        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        expect_low("commit_valid", commit_valid);
        expect_low("structural_hazard", structural_hazard);
        @(posedge clock);

        idx = 0;
        while (idx < tbl_op.size()) begin
            dispatch_valid <= 1'b1;
            dispatch_op    <= tbl_op[idx];
            dispatch_dest  <= tbl_dest[idx];
            dispatch_src1  <= tbl_src1[idx];
            dispatch_src2  <= tbl_src2[idx];
            dispatch_imm   <= tbl_imm[idx];
            // hazard only moves on a clock edge
            @(negedge clock);
            held = structural_hazard;
            @(posedge clock);
            // held until the hazard drops
            if (held) begin
                saw_hazard = 1'b1;
            end else begin
                idx = idx + 1;
            end
        end
        dispatch_valid <= 1'b0;

        while (exp_dest.size() != 0) begin
            @(negedge clock);
        end
        // quiet window to catch extra commits
        repeat (20) @(posedge clock);

        if (saw_hazard) begin
            $display("%0d commits matched the model", commits_seen);
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR: back-to-back dispatch never raised structural_hazard");
            end_in_failure();
        end
    end

endmodule

// File: list.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/rename_map.sv
rtl/phys_regfile.sv
rtl/issue_queue.sv
rtl/exec_unit.sv
rtl/reorder_buffer.sv
rtl/ooo.sv
dv/ooo_tb.sv

// File: rtl/exec_unit.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module exec_unit
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  issue_valid,
    input  op_e   issue_op,
    input  word_t issue_a,
    input  word_t issue_b,
    input  prn_t  issue_prn,
    input  robn_t issue_robn,
    output logic  alu_avail,
    output logic  mul_avail,
    output logic  cdb_valid,
    output prn_t  cdb_prn,
    output robn_t cdb_robn,
    output word_t cdb_value
);

    localparam int LAST = `MUL_LATENCY - 1;

    word_t alu_result;
    logic  alu_valid;
    prn_t  alu_prn;
    robn_t alu_robn;
    word_t alu_value;

    // one bit per multiply stage, doubles as the CDB slot reservation
    logic [`MUL_LATENCY-1:0] slot_resv;
    prn_t  mul_prn   [`MUL_LATENCY];
    robn_t mul_robn  [`MUL_LATENCY];
    word_t mul_value [`MUL_LATENCY];

    always_comb begin
        case (issue_op)
            OP_ADD:  alu_result = issue_a + issue_b;
            OP_SUB:  alu_result = issue_a - issue_b;
            OP_AND:  alu_result = issue_a & issue_b;
            OP_XOR:  alu_result = issue_a ^ issue_b;
            default: alu_result = issue_a;
        endcase
    end

    // a multiply about to leave owns next cycle's CDB
    assign alu_avail = !slot_resv[LAST-1];
    assign mul_avail = 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            slot_resv <= '0;
        end else begin
            alu_valid <= issue_valid && (issue_op != OP_MUL);
            slot_resv <= {slot_resv[LAST-1:0], issue_valid && (issue_op == OP_MUL)};
        end
    end

    always_ff @(posedge clock) begin
        alu_prn      <= issue_prn;
        alu_robn     <= issue_robn;
        alu_value    <= alu_result;
        // low half of the product only
        mul_prn[0]   <= issue_prn;
        mul_robn[0]  <= issue_robn;
        mul_value[0] <= issue_a * issue_b;
        for (int s = 1; s < `MUL_LATENCY; s++) begin
            mul_prn[s]   <= mul_prn[s-1];
            mul_robn[s]  <= mul_robn[s-1];
            mul_value[s] <= mul_value[s-1];
        end
    end

    assign cdb_valid = alu_valid || slot_resv[LAST];
    assign cdb_prn   = slot_resv[LAST] ? mul_prn[LAST]   : alu_prn;
    assign cdb_robn  = slot_resv[LAST] ? mul_robn[LAST]  : alu_robn;
    assign cdb_value = slot_resv[LAST] ? mul_value[LAST] : alu_value;

    assert property (@(posedge clock) disable iff (!rst_n) !(alu_valid && slot_resv[LAST]));

endmodule

// File: rtl/issue_queue.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module issue_queue
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  insert_en,
    input  op_e   insert_op,
    input  word_t insert_op1,
    input  word_t insert_op2,
    input  logic  insert_rdy1,
    input  logic  insert_rdy2,
    input  word_t insert_imm,
    input  prn_t  insert_prn,
    input  robn_t insert_robn,
    input  logic  cdb_valid,
    input  prn_t  cdb_prn,
    input  word_t cdb_value,
    input  logic  alu_avail,
    input  logic  mul_avail,
    output logic  issue_valid,
    output op_e   issue_op,
    output word_t issue_a,
    output word_t issue_b,
    output prn_t  issue_prn,
    output robn_t issue_robn,
    output logic  iq_full
);

    localparam int IDX_W = $clog2(`IQ_DEPTH);

    // waiting operands keep their tag in the low bits
    typedef struct packed {
        op_e   op;
        word_t op1;
        word_t op2;
        logic  rdy1;
        logic  rdy2;
        word_t imm;
        prn_t  prn;
        robn_t robn;
    } iq_entry_t;

    // slot 0 is the oldest, entries stay packed toward it
    iq_entry_t entries      [`IQ_DEPTH];
    iq_entry_t woken        [`IQ_DEPTH];
    iq_entry_t next_entries [`IQ_DEPTH];

    logic [IDX_W:0]        count;
    logic [IDX_W:0]        next_count;
    logic [IDX_W-1:0]      sel_idx;
    logic [`IQ_DEPTH-1:0]  can_issue;

    assign iq_full = (count == (IDX_W+1)'(`IQ_DEPTH));

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            woken[i] = entries[i];
            if (cdb_valid && !entries[i].rdy1 && entries[i].op1[$bits(prn_t)-1:0] == cdb_prn) begin
                woken[i].op1  = cdb_value;
                woken[i].rdy1 = 1'b1;
            end
            if (cdb_valid && !entries[i].rdy2 && entries[i].op2[$bits(prn_t)-1:0] == cdb_prn) begin
                woken[i].op2  = cdb_value;
                woken[i].rdy2 = 1'b1;
            end
            can_issue[i] = (i < count)
                && ((woken[i].op == OP_LI) || (woken[i].rdy1 && woken[i].rdy2))
                && ((woken[i].op == OP_MUL) ? mul_avail : alu_avail);
        end
    end

    // lowest index wins
    always_comb begin
        issue_valid = 1'b0;
        sel_idx     = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (can_issue[i]) begin
                issue_valid = 1'b1;
                sel_idx     = IDX_W'(i);
            end
        end
    end

    assign issue_op   = woken[sel_idx].op;
    assign issue_a    = (woken[sel_idx].op == OP_LI) ? woken[sel_idx].imm : woken[sel_idx].op1;
    assign issue_b    = woken[sel_idx].op2;
    assign issue_prn  = woken[sel_idx].prn;
    assign issue_robn = woken[sel_idx].robn;

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            next_entries[i] = woken[i];
        end
        // close the gap left by the issued entry
        if (issue_valid) begin
            for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
                if (i >= sel_idx) begin
                    next_entries[i] = woken[i+1];
                end
            end
        end
        next_count = count - (IDX_W+1)'(issue_valid);
        if (insert_en) begin
            next_entries[next_count[IDX_W-1:0]] = '{
                op: insert_op, op1: insert_op1, op2: insert_op2,
                rdy1: insert_rdy1, rdy2: insert_rdy2, imm: insert_imm,
                prn: insert_prn, robn: insert_robn
            };
            next_count = next_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= next_count;
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

    assert property (@(posedge clock) disable iff (!rst_n) !(insert_en && iq_full));

endmodule

// File: rtl/ooo.sv
`timescale 1ns/10ps

module ooo
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  dispatch_valid,
    input  op_e   dispatch_op,
    input  arn_t  dispatch_dest,
    input  arn_t  dispatch_src1,
    input  arn_t  dispatch_src2,
    input  word_t dispatch_imm,
    output logic  structural_hazard,
    output logic  commit_valid,
    output logic  commit_wr_en,
    output arn_t  commit_dest,
    output word_t commit_value
);

    logic  accept;
    prn_t  src1_prn, src2_prn, new_prn, old_prn;
    logic  free_empty, iq_full, rob_full;
    word_t rd1_value, rd2_value;
    logic  rd1_ready, rd2_ready;
    robn_t rob_tail;
    prn_t  commit_prn, commit_old_prn;

    logic  alu_avail, mul_avail;
    logic  issue_valid;
    op_e   issue_op;
    word_t issue_a, issue_b;
    prn_t  issue_prn;
    robn_t issue_robn;

    logic  cdb_valid;
    prn_t  cdb_prn;
    robn_t cdb_robn;
    word_t cdb_value;

    assign structural_hazard = rob_full || iq_full || free_empty;
    assign accept            = dispatch_valid && !structural_hazard;
    assign commit_wr_en      = (commit_dest != '0);

    rename_map rename_map_inst (
        .clock(clock), .rst_n(rst_n),
        .rename_en(accept),
        .src1(dispatch_src1), .src2(dispatch_src2), .dest(dispatch_dest),
        // dest 0 entries return nothing to the free list
        .commit_free(commit_valid && commit_wr_en),
        .commit_old_prn(commit_old_prn),
        .src1_prn(src1_prn), .src2_prn(src2_prn),
        .new_prn(new_prn), .old_prn(old_prn),
        .free_empty(free_empty)
    );

    phys_regfile phys_regfile_inst (
        .clock(clock), .rst_n(rst_n),
        .rd1_prn(src1_prn), .rd2_prn(src2_prn),
        .clear_prn(new_prn), .clear_en(accept && dispatch_dest != '0),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .commit_prn(commit_prn),
        .rd1_value(rd1_value), .rd2_value(rd2_value),
        .rd1_ready(rd1_ready), .rd2_ready(rd2_ready),
        .commit_value(commit_value)
    );

    // not-ready operands carry their tag instead of a value
    issue_queue issue_queue_inst (
        .clock(clock), .rst_n(rst_n),
        .insert_en(accept), .insert_op(dispatch_op),
        .insert_op1(rd1_ready ? rd1_value : word_t'(src1_prn)),
        .insert_op2(rd2_ready ? rd2_value : word_t'(src2_prn)),
        .insert_rdy1(rd1_ready), .insert_rdy2(rd2_ready),
        .insert_imm(dispatch_imm), .insert_prn(new_prn), .insert_robn(rob_tail),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .alu_avail(alu_avail), .mul_avail(mul_avail),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_prn(issue_prn), .issue_robn(issue_robn),
        .iq_full(iq_full)
    );

    exec_unit exec_unit_inst (
        .clock(clock), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_prn(issue_prn), .issue_robn(issue_robn),
        .alu_avail(alu_avail), .mul_avail(mul_avail),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn),
        .cdb_robn(cdb_robn), .cdb_value(cdb_value)
    );

    reorder_buffer reorder_buffer_inst (
        .clock(clock), .rst_n(rst_n),
        .alloc_en(accept), .alloc_dest(dispatch_dest),
        .alloc_prn(new_prn), .alloc_old_prn(old_prn),
        .cdb_valid(cdb_valid), .cdb_robn(cdb_robn),
        .rob_tail(rob_tail), .rob_full(rob_full),
        .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_prn(commit_prn), .commit_old_prn(commit_old_prn)
    );

endmodule

// File: rtl/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// architectural state, register 0 is hardwired to zero
`define ARCH_REGS 8

// physical tags, the ones above ARCH_REGS start on the free list
`define PHYS_REGS 16
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

// queue sizes
`define ROB_DEPTH 8
`define IQ_DEPTH 4

// datapath
`define XLEN 16
`define MUL_LATENCY 3

`endif

// File: rtl/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

    // data word
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] arn_t;

    // physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] prn_t;

    // reorder buffer index
    typedef logic [$clog2(`ROB_DEPTH)-1:0] robn_t;

    // integer opcodes, only OP_MUL goes to the long pipe
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LI  = 3'd4,
        OP_MUL = 3'd5
    } op_e;

endpackage

// File: rtl/phys_regfile.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module phys_regfile
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  prn_t  rd1_prn,
    input  prn_t  rd2_prn,
    input  prn_t  clear_prn,
    input  logic  clear_en,
    input  logic  cdb_valid,
    input  prn_t  cdb_prn,
    input  word_t cdb_value,
    input  prn_t  commit_prn,
    output word_t rd1_value,
    output word_t rd2_value,
    output logic  rd1_ready,
    output logic  rd2_ready,
    output word_t commit_value
);

    word_t values [`PHYS_REGS];
    logic  ready  [`PHYS_REGS];

    logic wr_en;

    // results of dest 0 instructions carry tag 0 and are dropped here
    assign wr_en = cdb_valid && (cdb_prn != '0);

    // same-cycle bypass from the CDB
    assign rd1_value = (wr_en && cdb_prn == rd1_prn) ? cdb_value : values[rd1_prn];
    assign rd2_value = (wr_en && cdb_prn == rd2_prn) ? cdb_value : values[rd2_prn];
    assign rd1_ready = ready[rd1_prn] || (wr_en && cdb_prn == rd1_prn);
    assign rd2_ready = ready[rd2_prn] || (wr_en && cdb_prn == rd2_prn);

    assign commit_value = values[commit_prn];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                ready[i] <= (i < `ARCH_REGS);
                if (i < `ARCH_REGS) begin
                    values[i] <= '0;
                end
            end
        end else begin
            if (wr_en) begin
                values[cdb_prn] <= cdb_value;
                ready[cdb_prn]  <= 1'b1;
            end
            // freshly allocated tag waits for its producer
            if (clear_en) begin
                ready[clear_prn] <= 1'b0;
            end
        end
    end

    // rename never hands out tag 0
    assert property (@(posedge clock) disable iff (!rst_n) !(clear_en && clear_prn == '0));

endmodule

// File: rtl/rename_map.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module rename_map
    import ooo_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    input  logic rename_en,
    input  arn_t src1,
    input  arn_t src2,
    input  arn_t dest,
    input  logic commit_free,
    input  prn_t commit_old_prn,
    output prn_t src1_prn,
    output prn_t src2_prn,
    output prn_t new_prn,
    output prn_t old_prn,
    output logic free_empty
);

    localparam int FREE_DEPTH = `FREE_DEPTH;
    localparam int PTR_W      = $clog2(FREE_DEPTH);

    prn_t map_table [`ARCH_REGS];
    prn_t free_list [FREE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;

    logic pop;
    logic push;

    // dest 0 never takes a tag
    assign pop  = rename_en && (dest != '0);
    assign push = commit_free;

    // sources see the map before this instruction's own update
    assign src1_prn   = map_table[src1];
    assign src2_prn   = map_table[src2];
    assign old_prn    = map_table[dest];
    assign new_prn    = (dest == '0) ? '0 : free_list[head];
    assign free_empty = (count == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            // identity map, upper tags free
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= prn_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= prn_t'(`ARCH_REGS + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (PTR_W+1)'(FREE_DEPTH);
        end else begin
            if (pop) begin
                map_table[dest] <= free_list[head];
                head            <= head + 1'b1;
            end
            if (push) begin
                free_list[tail] <= commit_old_prn;
                tail            <= tail + 1'b1;
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    // the top must hold dispatch while the free list is empty
    assert property (@(posedge clock) disable iff (!rst_n) !(pop && free_empty));

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/10ps
`include "ooo_macros.svh"

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  alloc_en,
    input  arn_t  alloc_dest,
    input  prn_t  alloc_prn,
    input  prn_t  alloc_old_prn,
    input  logic  cdb_valid,
    input  robn_t cdb_robn,
    output robn_t rob_tail,
    output logic  rob_full,
    output logic  commit_valid,
    output arn_t  commit_dest,
    output prn_t  commit_prn,
    output prn_t  commit_old_prn
);

    localparam int PTR_W = $clog2(`ROB_DEPTH);

    arn_t dest    [`ROB_DEPTH];
    prn_t prn     [`ROB_DEPTH];
    prn_t old_prn [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;

    robn_t          head;
    robn_t          tail;
    logic [PTR_W:0] count;
    robn_t          cdb_offset;

    assign rob_tail = tail;
    assign rob_full = (count == (PTR_W+1)'(`ROB_DEPTH));

    // head leaves as soon as its result is back
    assign commit_valid   = (count != '0) && done[head];
    assign commit_dest    = dest[head];
    assign commit_prn     = prn[head];
    assign commit_old_prn = old_prn[head];

    assign cdb_offset = cdb_robn - head;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_robn] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + (PTR_W+1)'(alloc_en) - (PTR_W+1)'(commit_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc_en) begin
            dest[tail]    <= alloc_dest;
            prn[tail]     <= alloc_prn;
            old_prn[tail] <= alloc_old_prn;
        end
    end

    // a result only comes back for an instruction still in flight
    assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid |-> ((PTR_W+1)'(cdb_offset) < count));

endmodule
